/* hw/local_mem_pkg.sv */
`default_nettype none

package local_mem_pkg;

  // Widths
  localparam int DATA_WIDTH        = 64;
  localparam int LINE_WIDTH        = 512;
  localparam int WORDS_PER_LINE    = LINE_WIDTH / DATA_WIDTH;
  localparam int WORD_SEL_WIDTH    = $clog2(WORDS_PER_LINE);
  localparam int ADDR_WIDTH        = 27;
  localparam int BYTEEN_WIDTH      = DATA_WIDTH / 8;
  localparam int LINE_BYTEEN_WIDTH = LINE_WIDTH / 8;
  localparam int BURSTCOUNT_WIDTH  = 7;

  // Control word fields
  localparam int CTRL_WR_A      = 0;
  localparam int CTRL_RD_A      = 1;
  localparam int CTRL_WR_B      = 2;
  localparam int CTRL_RD_B      = 3;
  localparam int CTRL_BE_LSB    = 4;
  localparam int CTRL_SEL_LSB   = 16;
  localparam int CTRL_BURST_LSB = 20;

  // Status word bits, everything above STAT_B_FULL reads as zero
  localparam int STAT_DATA_VALID = 0;
  localparam int STAT_A_WR_TO    = 1;
  localparam int STAT_A_RD_TO    = 2;
  localparam int STAT_A_FULL     = 3;
  localparam int STAT_B_WR_TO    = 4;
  localparam int STAT_B_RD_TO    = 5;
  localparam int STAT_B_FULL     = 6;

  typedef logic [LINE_WIDTH-1:0] line_t;

  typedef struct packed {
    logic                        write;
    logic                        read;
    logic [ADDR_WIDTH-1:0]       address;
    logic [DATA_WIDTH-1:0]       writedata;
    logic [BYTEEN_WIDTH-1:0]     byteenable;
    logic [BURSTCOUNT_WIDTH-1:0] burstcount;
    logic [WORD_SEL_WIDTH-1:0]   word_select;
  } mem_cmd_t;

  typedef struct packed {
    logic                         read;
    logic                         write;
    logic [ADDR_WIDTH-1:0]        address;
    line_t                        writedata;
    logic [LINE_BYTEEN_WIDTH-1:0] byteenable;
    logic [BURSTCOUNT_WIDTH-1:0]  burstcount;
  } ddr_req_t;

  typedef struct packed {
    logic  waitrequest;
    logic  readdatavalid;
    line_t readdata;
  } ddr_rsp_t;

endpackage

`default_nettype wire

/* hw/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = 4
) (
  input  wire        Clk_400,
  input  wire        rst,
  input  wire        push,
  input  wire item_t in,
  input  wire        pop,
  output item_t      out,
  output logic       empty,
  output logic       full
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  item_t                mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0] count;
  logic                 do_push;
  logic                 do_pop;

  // Wraps also for depths that are not a power of two
  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign empty   = (count == '0);
  assign full    = (count == CNT_WIDTH'(DEPTH));
  // Show-ahead, head is visible before pop
  assign out     = mem[rd_ptr];

  always_ff @(posedge Clk_400) begin
    if (do_push) begin
      mem[wr_ptr] <= in;
    end
  end

  always_ff @(posedge Clk_400) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/mem_if.sv */
`default_nettype none

module mem_if #(
  parameter int FIFO_DEPTH     = 4,
  parameter int TIMEOUT_CYCLES = 64
) (
  input  wire                                  Clk_400,
  input  wire                                  rst,
  input  wire local_mem_pkg::mem_cmd_t         cmd,
  input  wire                                  cmd_valid,
  output logic                                 cmd_full,
  input  wire                                  line_pop,
  output logic                                 line_ready,
  output logic [local_mem_pkg::DATA_WIDTH-1:0] word,
  output logic                                 write_timeout,
  output logic                                 read_timeout,
  output local_mem_pkg::ddr_req_t              req,
  input  wire local_mem_pkg::ddr_rsp_t         rsp
);

  localparam int DW       = local_mem_pkg::DATA_WIDTH;
  localparam int BW       = local_mem_pkg::BURSTCOUNT_WIDTH;
  localparam int SW       = local_mem_pkg::WORD_SEL_WIDTH;
  localparam int WORDS    = local_mem_pkg::WORDS_PER_LINE;
  localparam int WD_WIDTH = $clog2(TIMEOUT_CYCLES + 1);

  localparam logic [BW-1:0] BEAT_ONE = 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ_REQ,
    ST_READ_WAIT
  } state_t;

  state_t                  state;
  local_mem_pkg::mem_cmd_t head;
  logic                    cmd_empty;
  logic                    cmd_push;
  logic                    cmd_pop;
  local_mem_pkg::line_t    line_head;
  logic                    line_empty;
  logic                    line_full;
  logic                    line_push;
  logic [BW-1:0]           head_burst;
  logic [BW-1:0]           beat_cnt;
  logic [WD_WIDTH-1:0]     wd_cnt;
  logic                    wd_expired;
  logic                    read_after_write;
  logic [SW-1:0]           sel_q;
  logic [SW-1:0]           sel_s1;
  local_mem_pkg::line_t    line_s1;
  logic [DW-1:0]           word_s2;
  logic                    pop_d1;
  logic                    pop_d2;

  assign cmd_push = cmd_valid && !cmd_full;

  sync_fifo #(
    .item_t(local_mem_pkg::mem_cmd_t),
    .DEPTH (FIFO_DEPTH)
  ) cmd_q (
    .Clk_400(Clk_400),
    .rst    (rst),
    .push   (cmd_push),
    .in     (cmd),
    .pop    (cmd_pop),
    .out    (head),
    .empty  (cmd_empty),
    .full   (cmd_full)
  );

  sync_fifo #(
    .item_t(local_mem_pkg::line_t),
    .DEPTH (FIFO_DEPTH)
  ) line_q (
    .Clk_400(Clk_400),
    .rst    (rst),
    .push   (line_push),
    .in     (rsp.readdata),
    .pop    (line_pop),
    .out    (line_head),
    .empty  (line_empty),
    .full   (line_full)
  );

  // A read is only taken when its line has room to land
  assign cmd_pop    = (state == ST_IDLE) && !cmd_empty && !(head.read && line_full);
  assign line_push  = (state == ST_READ_WAIT) && rsp.readdatavalid;
  assign line_ready = !line_empty;
  assign head_burst = (head.burstcount == '0) ? BEAT_ONE : head.burstcount;
  assign wd_expired = (wd_cnt == WD_WIDTH'(TIMEOUT_CYCLES - 1));

  always_ff @(posedge Clk_400) begin
    if (rst) begin
      state            <= ST_IDLE;
      req.read         <= 1'b0;
      req.write        <= 1'b0;
      beat_cnt         <= '0;
      wd_cnt           <= '0;
      read_after_write <= 1'b0;
      write_timeout    <= 1'b0;
      read_timeout     <= 1'b0;
    end else begin
      // New command clears both flags, a timeout in the same cycle still wins
      if (cmd_push) begin
        write_timeout <= 1'b0;
        read_timeout  <= 1'b0;
      end
      case (state)
        ST_IDLE: begin
          wd_cnt   <= '0;
          beat_cnt <= '0;
          if (cmd_pop) begin
            req.address      <= head.address;
            req.writedata    <= {WORDS{head.writedata}};
            req.byteenable   <= {WORDS{head.byteenable}};
            read_after_write <= head.write && head.read;
            if (head.read) begin
              sel_q <= head.word_select;
            end
            if (head.write) begin
              req.write      <= 1'b1;
              req.burstcount <= head_burst;
              state          <= ST_WRITE;
            end else if (head.read) begin
              req.read       <= 1'b1;
              req.burstcount <= BEAT_ONE;
              state          <= ST_READ_REQ;
            end
          end
        end
        ST_WRITE: begin
          if (!rsp.waitrequest) begin
            wd_cnt <= '0;
            if (beat_cnt == req.burstcount - BEAT_ONE) begin
              req.write <= 1'b0;
              beat_cnt  <= '0;
              if (read_after_write) begin
                req.read       <= 1'b1;
                req.burstcount <= BEAT_ONE;
                state          <= ST_READ_REQ;
              end else begin
                state <= ST_IDLE;
              end
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end else if (wd_expired) begin
            req.write     <= 1'b0;
            write_timeout <= 1'b1;
            state         <= ST_IDLE;
          end else begin
            wd_cnt <= wd_cnt + 1'b1;
          end
        end
        ST_READ_REQ: begin
          if (!rsp.waitrequest) begin
            req.read <= 1'b0;
            wd_cnt   <= '0;
            state    <= ST_READ_WAIT;
          end else if (wd_expired) begin
            req.read     <= 1'b0;
            read_timeout <= 1'b1;
            state        <= ST_IDLE;
          end else begin
            wd_cnt <= wd_cnt + 1'b1;
          end
        end
        ST_READ_WAIT: begin
          if (rsp.readdatavalid) begin
            state <= ST_IDLE;
          end else if (wd_expired) begin
            // Late data after this point is dropped
            read_timeout <= 1'b1;
            state        <= ST_IDLE;
          end else begin
            wd_cnt <= wd_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge Clk_400) begin
    if (rst) begin
      pop_d1 <= 1'b0;
      pop_d2 <= 1'b0;
    end else begin
      pop_d1 <= line_pop && !line_empty;
      pop_d2 <= pop_d1;
    end
  end

  // Word select pipeline, word holds until the next pop
  always_ff @(posedge Clk_400) begin
    if (line_pop) begin
      line_s1 <= line_head;
      sel_s1  <= sel_q;
    end
    if (pop_d1) begin
      word_s2 <= line_s1[sel_s1*DW +: DW];
    end
    if (pop_d2) begin
      word <= word_s2;
    end
  end

endmodule

`default_nettype wire

/* hw/local_mem.sv */
`default_nettype none

module local_mem #(
  parameter int FIFO_DEPTH     = 4,
  parameter int TIMEOUT_CYCLES = 64
) (
  input  wire                                  Clk_400,
  input  wire                                  rst,
  input  wire [local_mem_pkg::DATA_WIDTH-1:0]  cr2mem_ctrl,
  input  wire [local_mem_pkg::DATA_WIDTH-1:0]  cr2mem_address,
  input  wire [local_mem_pkg::DATA_WIDTH-1:0]  cr2mem_writedata,
  output logic [local_mem_pkg::DATA_WIDTH-1:0] mem2cr_readdata,
  output logic [local_mem_pkg::DATA_WIDTH-1:0] mem2cr_status,
  output local_mem_pkg::ddr_req_t              ddr4a_req,
  input  wire local_mem_pkg::ddr_rsp_t         ddr4a_rsp,
  output local_mem_pkg::ddr_req_t              ddr4b_req,
  input  wire local_mem_pkg::ddr_rsp_t         ddr4b_rsp
);

  localparam int DW = local_mem_pkg::DATA_WIDTH;

  logic [DW-1:0]           ctrl_d0;
  logic [DW-1:0]           ctrl_d1;
  logic [3:0]              ctrl_prev;
  logic [DW-1:0]           addr_d0;
  logic [DW-1:0]           addr_d1;
  logic [DW-1:0]           wdata_d0;
  logic [DW-1:0]           wdata_d1;
  logic [3:0]              rise;
  logic [1:0]              rd_rise;
  local_mem_pkg::mem_cmd_t cmd_base;
  local_mem_pkg::mem_cmd_t cmd_a;
  local_mem_pkg::mem_cmd_t cmd_b;
  logic [1:0]              cmd_valid;
  logic [1:0]              cmd_full;
  logic [1:0]              line_ready;
  logic [1:0]              line_pop;
  logic [1:0]              wait_line;
  logic [1:0]              pop_start;
  logic [1:0]              wr_timeout;
  logic [1:0]              rd_timeout;
  logic [DW-1:0]           word_a;
  logic [DW-1:0]           word_b;
  logic                    bank_sel;
  logic [2:0]              vld_sr;
  logic                    data_valid;

  // Register inputs are levels from another domain and are taken twice
  always_ff @(posedge Clk_400) begin
    if (rst) begin
      ctrl_d0   <= '0;
      ctrl_d1   <= '0;
      ctrl_prev <= '0;
    end else begin
      ctrl_d0   <= cr2mem_ctrl;
      ctrl_d1   <= ctrl_d0;
      ctrl_prev <= ctrl_d1[3:0];
    end
  end

  always_ff @(posedge Clk_400) begin
    addr_d0  <= cr2mem_address;
    addr_d1  <= addr_d0;
    wdata_d0 <= cr2mem_writedata;
    wdata_d1 <= wdata_d0;
  end

  assign rise    = ctrl_d1[3:0] & ~ctrl_prev;
  assign rd_rise = {rise[local_mem_pkg::CTRL_RD_B], rise[local_mem_pkg::CTRL_RD_A]};

  // Fields shared by both banks
  always_comb begin
    cmd_base             = '0;
    cmd_base.address     = addr_d1[local_mem_pkg::ADDR_WIDTH-1:0];
    cmd_base.writedata   = wdata_d1;
    cmd_base.byteenable  =
      ctrl_d1[local_mem_pkg::CTRL_BE_LSB +: local_mem_pkg::BYTEEN_WIDTH];
    cmd_base.burstcount  =
      ctrl_d1[local_mem_pkg::CTRL_BURST_LSB +: local_mem_pkg::BURSTCOUNT_WIDTH];
    cmd_base.word_select =
      ctrl_d1[local_mem_pkg::CTRL_SEL_LSB +: local_mem_pkg::WORD_SEL_WIDTH];
  end

  always_ff @(posedge Clk_400) begin
    cmd_a       <= cmd_base;
    cmd_a.write <= rise[local_mem_pkg::CTRL_WR_A];
    cmd_a.read  <= rise[local_mem_pkg::CTRL_RD_A];
    cmd_b       <= cmd_base;
    cmd_b.write <= rise[local_mem_pkg::CTRL_WR_B];
    cmd_b.read  <= rise[local_mem_pkg::CTRL_RD_B];
  end

  always_ff @(posedge Clk_400) begin
    if (rst) begin
      cmd_valid <= '0;
    end else begin
      cmd_valid[0] <= rise[local_mem_pkg::CTRL_WR_A] | rise[local_mem_pkg::CTRL_RD_A];
      cmd_valid[1] <= rise[local_mem_pkg::CTRL_WR_B] | rise[local_mem_pkg::CTRL_RD_B];
    end
  end

  // Bit 0 is bank A, bit 1 is bank B
  assign pop_start = wait_line & line_ready & ~rd_rise;

  always_ff @(posedge Clk_400) begin
    if (rst) begin
      wait_line  <= '0;
      line_pop   <= '0;
      vld_sr     <= '0;
      bank_sel   <= 1'b0;
      data_valid <= 1'b0;
    end else begin
      wait_line <= (wait_line | rd_rise) & ~pop_start;
      line_pop  <= pop_start;
      vld_sr    <= {vld_sr[1:0], |pop_start};
      // Bank B wins when both reads start together
      if (|rd_rise) begin
        bank_sel <= rd_rise[1];
      end
      if (|rd_rise) begin
        data_valid <= 1'b0;
      end else if (vld_sr[2]) begin
        data_valid <= 1'b1;
      end
    end
  end

  assign mem2cr_readdata = bank_sel ? word_b : word_a;

  always_comb begin
    mem2cr_status                                 = '0;
    mem2cr_status[local_mem_pkg::STAT_DATA_VALID] = data_valid;
    mem2cr_status[local_mem_pkg::STAT_A_WR_TO]    = wr_timeout[0];
    mem2cr_status[local_mem_pkg::STAT_A_RD_TO]    = rd_timeout[0];
    mem2cr_status[local_mem_pkg::STAT_A_FULL]     = cmd_full[0];
    mem2cr_status[local_mem_pkg::STAT_B_WR_TO]    = wr_timeout[1];
    mem2cr_status[local_mem_pkg::STAT_B_RD_TO]    = rd_timeout[1];
    mem2cr_status[local_mem_pkg::STAT_B_FULL]     = cmd_full[1];
  end

  mem_if #(
    .FIFO_DEPTH    (FIFO_DEPTH),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) bank_a (
    .Clk_400      (Clk_400),
    .rst          (rst),
    .cmd          (cmd_a),
    .cmd_valid    (cmd_valid[0]),
    .cmd_full     (cmd_full[0]),
    .line_pop     (line_pop[0]),
    .line_ready   (line_ready[0]),
    .word         (word_a),
    .write_timeout(wr_timeout[0]),
    .read_timeout (rd_timeout[0]),
    .req          (ddr4a_req),
    .rsp          (ddr4a_rsp)
  );

  mem_if #(
    .FIFO_DEPTH    (FIFO_DEPTH),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) bank_b (
    .Clk_400      (Clk_400),
    .rst          (rst),
    .cmd          (cmd_b),
    .cmd_valid    (cmd_valid[1]),
    .cmd_full     (cmd_full[1]),
    .line_pop     (line_pop[1]),
    .line_ready   (line_ready[1]),
    .word         (word_b),
    .write_timeout(wr_timeout[1]),
    .read_timeout (rd_timeout[1]),
    .req          (ddr4b_req),
    .rsp          (ddr4b_rsp)
  );

endmodule

`default_nettype wire

/* dv/ddr_model.sv */
`default_nettype none

module ddr_model (
  input  wire                          Clk_400,
  input  wire                          rst,
  // 0 never, 1 every other cycle, 2 random, 3 always
  input  wire [1:0]                    wait_mode,
  input  wire local_mem_pkg::ddr_req_t req,
  output local_mem_pkg::ddr_rsp_t      rsp
);

  localparam int LATENCY = 5;

  local_mem_pkg::line_t lines [int];
  local_mem_pkg::line_t rd_data [LATENCY];
  logic [LATENCY-1:0]   rd_vld;
  logic [6:0]           beat;
  logic                 toggle;
  logic [31:0]          rnd;
  logic                 waitrequest;
  int                   seed = 37178;

  // Unwritten lines carry their address in every word
  function automatic local_mem_pkg::line_t line_at(input int a);
    local_mem_pkg::line_t l;
    if (lines.exists(a)) begin
      return lines[a];
    end
    for (int w = 0; w < 8; w++) begin
      l[w*64 +: 64] = {8'hf1, 5'h0, 27'(a), 21'h0, 3'(w)};
    end
    return l;
  endfunction

  function automatic local_mem_pkg::line_t merge_line(input local_mem_pkg::line_t old,
                                                      input local_mem_pkg::line_t data,
                                                      input logic [63:0] be);
    local_mem_pkg::line_t l;
    l = old;
    for (int b = 0; b < 64; b++) begin
      if (be[b]) begin
        l[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return l;
  endfunction

  always_comb begin
    case (wait_mode)
      2'd0:    waitrequest = 1'b0;
      2'd1:    waitrequest = toggle;
      2'd2:    waitrequest = rnd[0];
      default: waitrequest = 1'b1;
    endcase
  end

  assign rsp = {waitrequest, rd_vld[LATENCY-1], rd_data[LATENCY-1]};

  always @(posedge Clk_400) begin
    if (rst) begin
      rd_vld <= '0;
      beat   <= '0;
      toggle <= 1'b0;
      rnd    <= '0;
    end else begin
      toggle     <= !toggle;
      rnd        <= $random(seed);
      rd_vld     <= {rd_vld[LATENCY-2:0], req.read && !waitrequest};
      rd_data[0] <= line_at(int'(req.address));
      for (int i = 1; i < LATENCY; i++) begin
        rd_data[i] <= rd_data[i-1];
      end
      // Burst beats land on consecutive lines
      if (req.write && !waitrequest) begin
        lines[int'(req.address) + int'(beat)] =
          merge_line(line_at(int'(req.address) + int'(beat)), req.writedata, req.byteenable);
        if (beat == req.burstcount - 7'd1) begin
          beat <= '0;
        end else begin
          beat <= beat + 7'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/local_mem_checker.sv */
`default_nettype none

module local_mem_checker (
  input wire                          Clk_400,
  input wire                          rst,
  input wire local_mem_pkg::ddr_req_t req,
  input wire local_mem_pkg::ddr_rsp_t rsp,
  input wire                          wd_expired
);

  // A stalled beat may only be dropped by the watchdog
  property write_held;
    @(posedge Clk_400) disable iff (rst)
      (req.write && rsp.waitrequest && !wd_expired) |=>
        (req.write && $stable(req.address) && $stable(req.writedata) &&
         $stable(req.byteenable) && $stable(req.burstcount));
  endproperty

  property read_held;
    @(posedge Clk_400) disable iff (rst)
      (req.read && rsp.waitrequest && !wd_expired) |=>
        (req.read && $stable(req.address) && $stable(req.burstcount));
  endproperty

  assert_write_held: assert property (write_held)
    else $error("write request changed while waitrequest was high");

  assert_read_held: assert property (read_held)
    else $error("read request changed while waitrequest was high");

  assert_one_op: assert property (@(posedge Clk_400) disable iff (rst)
    !(req.read && req.write))
    else $error("read and write requested in the same cycle");

endmodule

bind mem_if local_mem_checker chk (
  .Clk_400   (Clk_400),
  .rst       (rst),
  .req       (req),
  .rsp       (rsp),
  .wd_expired(wd_expired)
);

`default_nettype wire

/* dv/local_mem_tb.sv */
`default_nettype none

module local_mem_tb;

  localparam int FIFO_DEPTH     = 4;
  localparam int TIMEOUT_CYCLES = 64;
  // Roughly 50 commands of under 100 cycles each, plus the watchdog wait, with wide margin
  localparam int CYCLE_LIMIT    = 20000;
  localparam int READ_LIMIT     = 300;
  localparam logic [1:0] WAIT_NEVER  = 2'd0;
  localparam logic [1:0] WAIT_TOGGLE = 2'd1;
  localparam logic [1:0] WAIT_RANDOM = 2'd2;
  localparam logic [1:0] WAIT_ALWAYS = 2'd3;

  logic                    Clk_400;
  logic                    rst;
  logic [63:0]             cr2mem_ctrl;
  logic [63:0]             cr2mem_address;
  logic [63:0]             cr2mem_writedata;
  logic [63:0]             mem2cr_readdata;
  logic [63:0]             mem2cr_status;
  local_mem_pkg::ddr_req_t ddr4a_req;
  local_mem_pkg::ddr_rsp_t ddr4a_rsp;
  local_mem_pkg::ddr_req_t ddr4b_req;
  local_mem_pkg::ddr_rsp_t ddr4b_rsp;
  logic [1:0]              wait_a;
  logic [1:0]              wait_b;
  logic [63:0]             ref_mem [int];
  int                      errors;
  int                      checks;
  int                      cycles;
  int                      seed = 37178;

  local_mem #(
    .FIFO_DEPTH    (FIFO_DEPTH),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) dut (
    .Clk_400         (Clk_400),
    .rst             (rst),
    .cr2mem_ctrl     (cr2mem_ctrl),
    .cr2mem_address  (cr2mem_address),
    .cr2mem_writedata(cr2mem_writedata),
    .mem2cr_readdata (mem2cr_readdata),
    .mem2cr_status   (mem2cr_status),
    .ddr4a_req       (ddr4a_req),
    .ddr4a_rsp       (ddr4a_rsp),
    .ddr4b_req       (ddr4b_req),
    .ddr4b_rsp       (ddr4b_rsp)
  );

  ddr_model ddr_a (
    .Clk_400  (Clk_400),
    .rst      (rst),
    .wait_mode(wait_a),
    .req      (ddr4a_req),
    .rsp      (ddr4a_rsp)
  );

  ddr_model ddr_b (
    .Clk_400  (Clk_400),
    .rst      (rst),
    .wait_mode(wait_b),
    .req      (ddr4b_req),
    .rsp      (ddr4b_rsp)
  );

  initial begin
    Clk_400 = 1'b0;
    forever #2 Clk_400 = ~Clk_400;
  end

  // Returns one time unit after a rising edge, where inputs change
  task automatic tick(input int n);
    repeat (n) @(posedge Clk_400);
    #1;
  endtask

  task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
                                              input logic [7:0] be);
    logic [63:0] w;
    w = old;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        w[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return w;
  endfunction

  // Lines the DDR model never wrote hold their address and word index
  function automatic logic [63:0] fill_word(input logic [26:0] addr, input logic [2:0] sel);
    return {8'hf1, 5'h0, addr, 21'h0, sel};
  endfunction

  function automatic int line_key(input logic bank, input logic [26:0] addr);
    return {4'h0, bank, addr};
  endfunction

  function automatic logic [63:0] ctrl_word(input int op_bit, input logic [7:0] be,
                                            input logic [2:0] sel, input logic [6:0] burst);
    logic [63:0] c;
    c = '0;
    c[op_bit] = 1'b1;
    c[local_mem_pkg::CTRL_BE_LSB +: 8]    = be;
    c[local_mem_pkg::CTRL_SEL_LSB +: 3]   = sel;
    c[local_mem_pkg::CTRL_BURST_LSB +: 7] = burst;
    return c;
  endfunction

  // Bit held two cycles then low one, so each call is one rising edge
  task automatic pulse_ctrl(input logic [63:0] ctrl, input logic [26:0] addr,
                            input logic [63:0] data);
    cr2mem_ctrl      = ctrl;
    cr2mem_address   = 64'(addr);
    cr2mem_writedata = data;
    tick(2);
    cr2mem_ctrl = '0;
    tick(1);
  endtask

  task automatic wait_for_room(input logic bank);
    while (mem2cr_status[bank ? local_mem_pkg::STAT_B_FULL : local_mem_pkg::STAT_A_FULL]) begin
      tick(1);
    end
  endtask

  task automatic poll_data_valid(output bit ok);
    int n;
    n = 0;
    while (!mem2cr_status[local_mem_pkg::STAT_DATA_VALID] && n < READ_LIMIT) begin
      tick(1);
      n++;
    end
    ok = mem2cr_status[local_mem_pkg::STAT_DATA_VALID];
    if (!ok) begin
      errors++;
      $display("no read data arrived within %0d cycles at %0t", READ_LIMIT, $time);
    end
  endtask

  task automatic write_word(input logic bank, input logic [26:0] addr, input logic [63:0] data,
                            input logic [7:0] be, input logic [6:0] burst);
    int k;
    wait_for_room(bank);
    pulse_ctrl(ctrl_word(bank ? local_mem_pkg::CTRL_WR_B : local_mem_pkg::CTRL_WR_A,
                         be, 3'd0, burst), addr, data);
    for (int i = 0; i < int'(burst); i++) begin
      k = line_key(bank, addr + 27'(i));
      ref_mem[k] = merge_bytes(ref_mem.exists(k) ? ref_mem[k] : '0, data, be);
    end
  endtask

  task automatic read_word(input logic bank, input logic [26:0] addr, input logic [2:0] sel);
    bit          ok;
    string       what;
    logic [63:0] expected;
    what = $sformatf("bank %0d address %h word %0d", bank, addr, sel);
    if (ref_mem.exists(line_key(bank, addr))) begin
      expected = ref_mem[line_key(bank, addr)];
    end else begin
      expected = fill_word(addr, sel);
    end
    wait_for_room(bank);
    pulse_ctrl(ctrl_word(bank ? local_mem_pkg::CTRL_RD_B : local_mem_pkg::CTRL_RD_A,
                         8'h00, sel, 7'd1), addr, '0);
    compare(64'(mem2cr_status[local_mem_pkg::STAT_DATA_VALID]), 64'd0,
            {what, " data valid after read edge"});
    poll_data_valid(ok);
    if (ok) begin
      compare(mem2cr_readdata, expected, what);
    end
  endtask

  task automatic word_select_test;
    wait_a = WAIT_TOGGLE;
    write_word(1'b0, 27'h10, 64'h0f1e_2d3c_4b5a_6978, 8'hff, 7'd2);
    for (int s = 0; s < 8; s++) begin
      read_word(1'b0, 27'h10, 3'(s));
    end
    read_word(1'b0, 27'h11, 3'd6);
    // An unwritten line holds a different value in every word
    for (int s = 0; s < 8; s++) begin
      read_word(1'b0, 27'h20, 3'(s));
    end
    wait_a = WAIT_NEVER;
  endtask

  task automatic bank_isolation_test;
    write_word(1'b0, 27'h40, 64'haaaa_0000_1111_2222, 8'hff, 7'd1);
    write_word(1'b1, 27'h40, 64'h5555_ffff_3333_4444, 8'hff, 7'd1);
    read_word(1'b0, 27'h40, 3'd1);
    read_word(1'b1, 27'h40, 3'd4);
  endtask

  task automatic byte_enable_test;
    write_word(1'b1, 27'h30, 64'h1122_3344_5566_7788, 8'hff, 7'd1);
    write_word(1'b1, 27'h30, 64'haabb_ccdd_eeff_0011, 8'h5a, 7'd1);
    read_word(1'b1, 27'h30, 3'd5);
    write_word(1'b0, 27'h30, 64'h0123_4567_89ab_cdef, 8'hff, 7'd1);
    write_word(1'b0, 27'h30, 64'hfedc_ba98_7654_3210, 8'h81, 7'd1);
    read_word(1'b0, 27'h30, 3'd2);
  endtask

  task automatic random_wait_test;
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    logic        bank;
    logic [26:0] addr;
    wait_a = WAIT_RANDOM;
    wait_b = WAIT_RANDOM;
    for (int i = 0; i < 20; i++) begin
      r    = $random(seed);
      hi   = $random(seed);
      lo   = $random(seed);
      bank = r[0];
      addr = 27'h100 + 27'(r[2:1]);
      // First write to a line is always a full word
      if (!ref_mem.exists(line_key(bank, addr))) begin
        write_word(bank, addr, {hi, lo}, 8'hff, 7'd1);
      end else if (r[3]) begin
        read_word(bank, addr, r[6:4]);
      end else begin
        write_word(bank, addr, {hi, lo}, r[15:8], 7'd1);
      end
    end
    wait_a = WAIT_NEVER;
    wait_b = WAIT_NEVER;
  endtask

  task automatic write_watchdog_test;
    int n;
    wait_a = WAIT_ALWAYS;
    // The write is abandoned and leaves the reference unchanged
    pulse_ctrl(ctrl_word(local_mem_pkg::CTRL_WR_A, 8'hff, 3'd0, 7'd1), 27'h10,
               64'hdead_beef_0bad_f00d);
    n = 3;
    while (!mem2cr_status[local_mem_pkg::STAT_A_WR_TO] && n < TIMEOUT_CYCLES + 10) begin
      tick(1);
      n++;
    end
    if (!mem2cr_status[local_mem_pkg::STAT_A_WR_TO]) begin
      errors++;
      $display("bank A write timeout flag was not set within %0d cycles", n);
    end
    compare(mem2cr_status & ~(64'd1 << local_mem_pkg::STAT_DATA_VALID),
            64'd1 << local_mem_pkg::STAT_A_WR_TO, "status after write timeout");
    wait_a = WAIT_NEVER;
    tick(2);
    read_word(1'b0, 27'h10, 3'd0);
    compare(mem2cr_status, 64'd1 << local_mem_pkg::STAT_DATA_VALID,
            "status after new command");
  endtask

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge Clk_400);
      cycles++;
    end
    $display("run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("checks: %0d  errors: %0d", checks, errors + 1);
    $display("sim failed");
    $finish;
  end

  initial begin
    errors           = 0;
    checks           = 0;
    rst              = 1'b1;
    cr2mem_ctrl      = '0;
    cr2mem_address   = '0;
    cr2mem_writedata = '0;
    wait_a           = WAIT_NEVER;
    wait_b           = WAIT_NEVER;
    tick(10);
    rst = 1'b0;
    tick(2);
    word_select_test();
    bank_isolation_test();
    byte_enable_test();
    random_wait_test();
    write_watchdog_test();
    tick(5);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hw/local_mem_pkg.sv
hw/sync_fifo.sv
hw/mem_if.sv
hw/local_mem.sv
dv/ddr_model.sv
dv/local_mem_checker.sv
dv/local_mem_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module local_mem_tb -f tb.f \
  --Mdir obj_dir -o local_mem_tb_sim

./obj_dir/local_mem_tb_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
  exit 0
fi
exit 1
